// File: common/frame_dispatch_pkg.sv
// Shared definitions for the frame dispatcher.
// Covers lane count, word and field widths, and the header, beat and result
// layouts. Files refer to these by scoped name.
`default_nettype none

package frame_dispatch_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------

  // Output lanes, one per header lane code
  localparam int NUM_LANES = 4;
  // Lane index width
  localparam int LANE_W = 2;
  // Input word width
  localparam int DATA_W = 16;
  // Length field, holds payload length minus one
  localparam int LEN_W = 4;
  // Beat count, up to 16 beats per frame
  localparam int CNT_W = 5;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------

  // One input word as it arrives on the stream
  typedef logic [DATA_W-1:0] word_t;

  // Header word layout, MSB first
  typedef struct packed {
    logic [DATA_W-LANE_W-LEN_W-1:0] reserved;
    // Destination lane
    logic [LANE_W-1:0]              lane;
    // Payload length minus one, 0 means a single word
    logic [LEN_W-1:0]               len_m1;
  } header_t;

  // One payload beat as seen by a lane
  typedef struct packed {
    word_t data;
    // Final beat of the frame
    logic  last;
  } lane_beat_t;

  // Per-frame lane result
  typedef struct packed {
    // Modulo 2^16 sum of the payload words
    logic [DATA_W-1:0] sum;
    // Payload beats seen
    logic [CNT_W-1:0]  count;
  } frame_result_t;

endpackage : frame_dispatch_pkg

`default_nettype wire

// File: verilog/beat_demux.sv
// Binary select demultiplexer, 1 to NUM_OUT.
// The input is copied to every output and only the selected output is
// marked valid, and only while the input is valid. Purely combinational.
`default_nettype none

module beat_demux #(
  // Payload carried on each output
  parameter type payload_t = frame_dispatch_pkg::lane_beat_t,
  // Output count, select must stay below it
  parameter int  NUM_OUT   = frame_dispatch_pkg::NUM_LANES
) (
  // Binary encoded destination
  input  logic [frame_dispatch_pkg::LANE_W-1:0] select,
  input  logic                                  in_valid,
  input  payload_t                              in,
  // At most one bit set
  output logic [NUM_OUT-1:0]                    out_valid,
  output payload_t [NUM_OUT-1:0]                out
);

  // ------------------------------------------------------------
  // Decode and fan out
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_OUT; i++) begin
      // Every output sees the same payload
      out[i]       = in;
      out_valid[i] = in_valid && (select == frame_dispatch_pkg::LANE_W'(i));
    end
  end

endmodule : beat_demux

`default_nettype wire

// File: verilog/lane_checksum.sv
// Per-lane frame checksum.
// Accumulates a modulo 2^16 sum and a beat count over one frame. On the
// last beat the totals are registered, result_valid pulses for a cycle
// and the accumulators restart for the next frame.
`default_nettype none

module lane_checksum (
  input  logic                              clk,
  input  logic                              rst,
  // Beat addressed to this lane
  input  logic                              beat_valid,
  input  frame_dispatch_pkg::lane_beat_t    beat,
  // One cycle pulse per completed frame
  output logic                              result_valid,
  output frame_dispatch_pkg::frame_result_t result
);

  // Running totals of the open frame
  logic [frame_dispatch_pkg::DATA_W-1:0] sum_q;
  logic [frame_dispatch_pkg::CNT_W-1:0]  count_q;

  // Totals including the current beat
  logic [frame_dispatch_pkg::DATA_W-1:0] sum_next;
  logic [frame_dispatch_pkg::CNT_W-1:0]  count_next;

  // Carry out of the sum is dropped, so it wraps at 16 bits
  assign sum_next   = sum_q + beat.data;
  assign count_next = count_q + 1'b1;

  // ------------------------------------------------------------
  // Accumulators
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      sum_q   <= '0;
      count_q <= '0;
    end else if (beat_valid) begin
      if (beat.last) begin
        // Frame done, start clean
        sum_q   <= '0;
        count_q <= '0;
      end else begin
        sum_q   <= sum_next;
        count_q <= count_next;
      end
    end
  end

  // ------------------------------------------------------------
  // Result
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= beat_valid && beat.last;
    end
  end

  // Captured with the closing beat, held until the next frame ends
  always_ff @(posedge clk) begin
    if (beat_valid && beat.last) begin
      result.sum   <= sum_next;
      result.count <= count_next;
    end
  end

endmodule : lane_checksum

`default_nettype wire

// File: control/beat_counter.sv
// Payload beat counter.
// Loaded with the frame length minus one on the header and stepped once
// per payload beat; last flags the beat that closes the frame.
`default_nettype none

module beat_counter (
  input  logic                                 clk,
  input  logic                                 rst,
  // Header accepted, take a new length
  input  logic                                 load,
  input  logic [frame_dispatch_pkg::LEN_W-1:0] len_m1,
  // One payload beat consumed
  input  logic                                 step,
  output logic                                 last
);

  // Beats left after the current one
  logic [frame_dispatch_pkg::LEN_W-1:0] remain_q;

  // ------------------------------------------------------------
  // Down counter
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      remain_q <= '0;
    end else if (load) begin
      remain_q <= len_m1;
    end else if (step && (remain_q != '0)) begin
      // Stops at zero, the last beat leaves it there
      remain_q <= remain_q - 1'b1;
    end
  end

  // Zero left means the current beat ends the frame
  assign last = (remain_q == '0);

endmodule : beat_counter

`default_nettype wire

// File: control/frame_sequencer.sv
// Frame sequencer for the dispatcher.
// Splits the word stream into headers and payload, holds the destination
// lane for the frame and drives the beat counter and the demux.
`default_nettype none

module frame_sequencer (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 in_valid,
  input  frame_dispatch_pkg::word_t            in_word,
  // High when the current payload beat is the final one
  input  logic                                 last,
  output logic                                 load,
  output logic [frame_dispatch_pkg::LEN_W-1:0] len_m1,
  output logic                                 step,
  output logic [frame_dispatch_pkg::LANE_W-1:0] select,
  output logic                                 beat_valid,
  output frame_dispatch_pkg::lane_beat_t       beat,
  output logic                                 busy
);

  typedef enum logic {
    S_IDLE,
    S_PAYLOAD
  } state_t;

  state_t                              state_q;
  state_t                              state_d;
  frame_dispatch_pkg::header_t         hdr;
  // Destination lane of the frame in flight
  logic [frame_dispatch_pkg::LANE_W-1:0] lane_q;

  // Header view of the incoming word, only meaningful while idle
  assign hdr = in_word;

  // ------------------------------------------------------------
  // Next state and strobes
  // ------------------------------------------------------------
  always_comb begin
    state_d    = state_q;
    load       = 1'b0;
    step       = 1'b0;
    beat_valid = 1'b0;
    case (state_q)
      S_IDLE: begin
        // Any valid word here is a header
        if (in_valid) begin
          load    = 1'b1;
          state_d = S_PAYLOAD;
        end
      end
      S_PAYLOAD: begin
        // Gaps in valid simply hold the frame
        if (in_valid) begin
          step       = 1'b1;
          beat_valid = 1'b1;
          if (last) begin
            state_d = S_IDLE;
          end
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  // ------------------------------------------------------------
  // State and lane registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Lane captured with the header
  always_ff @(posedge clk) begin
    if (load) begin
      lane_q <= hdr.lane;
    end
  end

  // Length goes straight to the counter on the load cycle
  assign len_m1    = hdr.len_m1;
  assign select    = lane_q;
  assign beat.data = in_word;
  assign beat.last = last;
  assign busy      = (state_q == S_PAYLOAD);

endmodule : frame_sequencer

`default_nettype wire

// File: verilog/frame_dispatch_top.sv
// Frame dispatcher top level.
// Headers pick a lane and length; payload words are steered to that lane,
// which reports the frame sum and beat count one cycle after the last word.
`default_nettype none

module frame_dispatch_top (
  input  logic                                                     clk,
  input  logic                                                     rst,
  input  logic                                                     in_valid,
  input  frame_dispatch_pkg::word_t                                in_word,
  // Frame in progress
  output logic                                                     busy,
  output logic [frame_dispatch_pkg::NUM_LANES-1:0]                 result_valid,
  output frame_dispatch_pkg::frame_result_t [frame_dispatch_pkg::NUM_LANES-1:0] result
);

  // Sequencer to counter
  logic                                  ctr_load;
  logic [frame_dispatch_pkg::LEN_W-1:0]  ctr_len_m1;
  logic                                  ctr_step;
  logic                                  ctr_last;

  // Sequencer to demux
  logic [frame_dispatch_pkg::LANE_W-1:0] beat_select;
  logic                                  beat_valid;
  frame_dispatch_pkg::lane_beat_t        beat;

  // Demux to lanes
  logic [frame_dispatch_pkg::NUM_LANES-1:0]                        lane_valid;
  frame_dispatch_pkg::lane_beat_t [frame_dispatch_pkg::NUM_LANES-1:0] lane_beat;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------
  frame_sequencer u_sequencer (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_word    (in_word),
    .last       (ctr_last),
    .load       (ctr_load),
    .len_m1     (ctr_len_m1),
    .step       (ctr_step),
    .select     (beat_select),
    .beat_valid (beat_valid),
    .beat       (beat),
    .busy       (busy)
  );

  beat_counter u_counter (
    .clk    (clk),
    .rst    (rst),
    .load   (ctr_load),
    .len_m1 (ctr_len_m1),
    .step   (ctr_step),
    .last   (ctr_last)
  );

  // ------------------------------------------------------------
  // Lane steering
  // ------------------------------------------------------------
  beat_demux #(
    .payload_t (frame_dispatch_pkg::lane_beat_t),
    .NUM_OUT   (frame_dispatch_pkg::NUM_LANES)
  ) u_demux (
    .select    (beat_select),
    .in_valid  (beat_valid),
    .in        (beat),
    .out_valid (lane_valid),
    .out       (lane_beat)
  );

  // One checksum unit per lane
  for (genvar g = 0; g < frame_dispatch_pkg::NUM_LANES; g++) begin : gen_lane
    lane_checksum u_lane (
      .clk          (clk),
      .rst          (rst),
      .beat_valid   (lane_valid[g]),
      .beat         (lane_beat[g]),
      .result_valid (result_valid[g]),
      .result       (result[g])
    );
  end

endmodule : frame_dispatch_top

`default_nettype wire

// File: verification/frame_dispatch_props.sv
// Concurrent checks on the frame dispatcher.
// Bound into the top level, watches the lane results, the demux decode
// and the sequencer handshake with the beat counter.
`default_nettype none

module frame_dispatch_props (
  input logic                                 clk,
  input logic                                 rst,
  input logic                                 busy,
  input logic                                 load,
  input logic [frame_dispatch_pkg::NUM_LANES-1:0] result_valid,
  // Demux lane valids
  input logic [frame_dispatch_pkg::NUM_LANES-1:0] demux_valid
);

  // ------------------------------------------------------------
  // Lane outputs
  // ------------------------------------------------------------
  // One frame ends per cycle at most
  a_result_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(result_valid))
    else $error("more than one lane result_valid at once");

  // Demux raises a single lane
  a_demux_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(demux_valid))
    else $error("demux drove several lanes");

  // ------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------
  // Idle right out of reset
  a_idle_after_reset: assert property (@(posedge clk)
    rst |=> !busy)
    else $error("busy high in the cycle after reset");

  // Headers only taken while idle
  a_no_load_busy: assert property (@(posedge clk) disable iff (rst)
    load |-> !busy)
    else $error("counter load during a frame");

endmodule : frame_dispatch_props

bind frame_dispatch_top frame_dispatch_props i_props (
  .clk          (clk),
  .rst          (rst),
  .busy         (busy),
  .load         (ctr_load),
  .result_valid (result_valid),
  .demux_valid  (lane_valid)
);

`default_nettype wire

// File: verification/tb_frame_dispatch.sv
// Testbench for the frame dispatcher.
// Sends random frames with random lanes, lengths, data and gaps, predicts each
// lane result from the words sent and checks results, their timing and busy.
`default_nettype none

module tb_frame_dispatch;

  localparam int          NUM_FRAMES = 300;
  localparam int          CLK_PERIOD = 20;
  localparam int          RST_CYCLES = 4;
  localparam logic [31:0] SEED       = 32'ha9a8_4acb;
  // Frames x (17 words + 8 gap cycles) x 2 margin x clock period
  localparam longint      WATCHDOG   = longint'(NUM_FRAMES) * (17 + 8) * 2 * CLK_PERIOD;

  logic                                                                  clk;
  logic                                                                  rst;
  logic                                                                  in_valid;
  frame_dispatch_pkg::word_t                                             in_word;
  logic                                                                  busy;
  logic [frame_dispatch_pkg::NUM_LANES-1:0]                              result_valid;
  frame_dispatch_pkg::frame_result_t [frame_dispatch_pkg::NUM_LANES-1:0] result;

  // Markers that travel with each driven word
  logic                                  drv_hdr;
  logic                                  drv_last;
  logic [frame_dispatch_pkg::LANE_W-1:0] drv_lane;

  // ------------------------------------------------------------
  // Reference model state
  // ------------------------------------------------------------
  // Expected results per lane, oldest first
  frame_dispatch_pkg::frame_result_t        exp_q [frame_dispatch_pkg::NUM_LANES][$];
  // Lanes whose result is due at the next sample
  logic [frame_dispatch_pkg::NUM_LANES-1:0] due_q;
  logic                                     exp_busy;
  int                                       value_errors;
  int                                       protocol_errors;

  frame_dispatch_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_word      (in_word),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_result(input string name,
                              input frame_dispatch_pkg::frame_result_t exp,
                              input frame_dispatch_pkg::frame_result_t act);
    if (act !== exp) begin
      value_errors++;
      $display("[ERROR] t=%0t %s expected sum=%h count=%0d, got sum=%h count=%0d",
               $time, name, exp.sum, exp.count, act.sum, act.count);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("[ERROR] t=%0t %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic report_protocol_error(input string msg);
    protocol_errors++;
    $display("t=%0t %s", $time, msg);
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  // One clock of input, markers follow the word
  task automatic drive_cycle(input logic valid, input frame_dispatch_pkg::word_t word,
                             input logic hdr, input logic last_word,
                             input logic [frame_dispatch_pkg::LANE_W-1:0] lane);
    @(posedge clk);
    in_valid <= valid;
    in_word  <= word;
    drv_hdr  <= hdr;
    drv_last <= last_word;
    drv_lane <= lane;
  endtask

  // Idle cycle with junk on the data lines
  task automatic drive_idle();
    drive_cycle(1'b0, frame_dispatch_pkg::word_t'($urandom), 1'b0, 1'b0, '0);
  endtask

  task automatic send_frame(input logic [frame_dispatch_pkg::LANE_W-1:0] lane,
                            input logic [frame_dispatch_pkg::LEN_W-1:0]  len_m1,
                            input bit                                     big_words);
    frame_dispatch_pkg::header_t       hdr;
    frame_dispatch_pkg::word_t         data;
    frame_dispatch_pkg::frame_result_t exp;
    int                                gap;
    hdr        = frame_dispatch_pkg::header_t'($urandom);
    hdr.lane   = lane;
    hdr.len_m1 = len_m1;
    exp.sum    = '0;
    // Count rule is len_m1 + 1
    exp.count  = frame_dispatch_pkg::CNT_W'(len_m1) + 5'd1;
    // Zero gap gives a header right after the previous last word
    gap = $urandom_range(0, 3);
    repeat (gap) drive_idle();
    drive_cycle(1'b1, hdr, 1'b1, 1'b0, lane);
    for (int i = 0; i <= int'(len_m1); i++) begin
      // Occasional pause inside the payload
      if ($urandom_range(0, 3) == 0) begin
        drive_idle();
      end
      // Large words force the sum to wrap
      data = big_words ? {2'b11, 14'($urandom)} : frame_dispatch_pkg::word_t'($urandom);
      exp.sum = exp.sum + data;
      if (i == int'(len_m1)) begin
        exp_q[lane].push_back(exp);
      end
      drive_cycle(1'b1, data, 1'b0, i == int'(len_m1), lane);
    end
  endtask

  // ------------------------------------------------------------
  // Monitor, samples mid cycle where everything is settled
  // ------------------------------------------------------------
  always @(negedge clk) begin
    frame_dispatch_pkg::frame_result_t exp;
    if (rst) begin
      due_q    = '0;
      exp_busy = 1'b0;
    end else begin
      check_flag("busy", exp_busy, busy);
      for (int l = 0; l < frame_dispatch_pkg::NUM_LANES; l++) begin
        if (result_valid[l] === 1'b1 && !due_q[l]) begin
          report_protocol_error($sformatf("lane %0d pulsed result_valid with no frame ending", l));
        end else if (result_valid[l] !== 1'b1 && due_q[l]) begin
          report_protocol_error($sformatf("lane %0d gave no result after its last word", l));
          void'(exp_q[l].pop_front());
        end else if (due_q[l]) begin
          exp = exp_q[l].pop_front();
          check_result($sformatf("result[%0d]", l), exp, result[l]);
        end
      end
      // Last word now means a result on its lane next cycle
      due_q = '0;
      if (drv_last) begin
        due_q[drv_lane] = 1'b1;
      end
      if (drv_hdr) begin
        exp_busy = 1'b1;
      end else if (drv_last) begin
        exp_busy = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    logic [frame_dispatch_pkg::LANE_W-1:0] lane;
    logic [frame_dispatch_pkg::LEN_W-1:0]  len_m1;
    int                                    seed_ret;
    seed_ret        = $urandom(SEED);
    clk             = 1'b0;
    rst             = 1'b1;
    in_valid        = 1'b0;
    in_word         = '0;
    drv_hdr         = 1'b0;
    drv_last        = 1'b0;
    drv_lane        = '0;
    value_errors    = 0;
    protocol_errors = 0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    // Quiet stretch, busy and result_valid must stay low
    repeat (3) drive_idle();
    for (int f = 0; f < NUM_FRAMES; f++) begin
      if (f < 8) begin
        // Shortest and longest frames on every lane first
        lane   = frame_dispatch_pkg::LANE_W'(f % 4);
        len_m1 = (f < 4) ? 4'd0 : 4'd15;
      end else begin
        lane   = frame_dispatch_pkg::LANE_W'($urandom);
        len_m1 = frame_dispatch_pkg::LEN_W'($urandom);
      end
      send_frame(lane, len_m1, (f % 5) == 0);
    end
    // Last result lands one cycle after the last word
    repeat (3) drive_idle();
    @(negedge clk);
    $display("Checks done: %0d value errors, %0d protocol errors",
             value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG);
    $display("Timeout: frames did not finish within %0d time units", WATCHDOG);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : tb_frame_dispatch

`default_nettype wire

// File: compile.f
common/frame_dispatch_pkg.sv
verilog/beat_demux.sv
verilog/lane_checksum.sv
control/beat_counter.sv
control/frame_sequencer.sv
verilog/frame_dispatch_top.sv
verification/frame_dispatch_props.sv
verification/tb_frame_dispatch.sv

// File: Makefile
# Verilator build and run for the frame dispatcher testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_frame_dispatch
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

# Sources taken from the file list, include lines skipped
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
